//--- rtl/dcache_icc_pkg.sv
//============================================================
// shared definitions for the L1 dcache maintenance controller
// walk FSM states, request type codes, cache geometry
//============================================================

package dcache_icc_pkg;

  // controller states, the active way is held outside the state
  typedef enum logic [4:0] {
    IDLE,
    INV_ALL,
    DIRTY_RD,
    DIRTY_WEN,
    CHECK,
    TAG_RD,
    TAG_WEN,
    WFVB,
    DATA,
    TAG_WT,
    CLR_VB
  } icc_state_e;

  // maintenance type field of the CP0 request
  localparam logic [1:0] ICC_TYPE_ALL    = 2'b00;
  localparam logic [1:0] ICC_TYPE_SETWAY = 2'b01;

  // 4-way cache geometry
  localparam int NUM_WAYS = 4;
  localparam int WAY_W    = 2;
  localparam int TAG_W    = 28;

  // one line is four 128-bit beats
  localparam int LINE_W = 128;
  localparam int BEAT_W = 2;

  localparam int DEFAULT_SET_W = 8;

endpackage

//--- rtl/icc_ctrl.sv
//============================================================
// maintenance request decode and walk FSM
// picks the next dirty way and drives the state strobes
//============================================================
`timescale 1ns/1ns

module icc_ctrl (
  input  logic                                 icc_fsm_clk,
  input  logic                                 cpurst_b,
  input  logic                                 icc_req,
  input  logic [1:0]                           icc_op,
  input  logic [1:0]                           icc_type,
  input  logic                                 lsu_no_op,
  input  logic                                 vb_idle,
  input  logic                                 vb_grant,
  input  logic                                 vb_empty,
  input  logic                                 dcache_tagvld,
  input  logic [dcache_icc_pkg::NUM_WAYS-1:0]  way_dirty,
  input  logic                                 cnt_done,
  input  logic                                 data_last,
  output logic                                 op_inv,
  output logic                                 op_cln,
  output logic                                 type_all,
  output logic                                 type_setway,
  output logic                                 cur_inv_all,
  output logic                                 cur_dirty_rd,
  output logic                                 cur_dirty_wen,
  output logic                                 cur_tag_rd,
  output logic                                 cur_tag_wen,
  output logic                                 cur_wfvb,
  output logic                                 cur_data,
  output logic                                 cur_tag_wt,
  output logic                                 cnt_start,
  output logic [dcache_icc_pkg::WAY_W-1:0]     cur_way,
  output logic                                 icc_done,
  output logic                                 sync_req,
  output logic                                 idle,
  output logic                                 vb_req
);

  dcache_icc_pkg::icc_state_e           state_q;
  dcache_icc_pkg::icc_state_e           state_d;
  logic                                 cur_idle;
  logic                                 inv_only;
  logic                                 walk_go;
  logic [dcache_icc_pkg::WAY_W-1:0]     first_way;

  //============================================================
  // request decode
  //============================================================
  assign op_inv      = icc_req & icc_op[0];
  assign op_cln      = icc_req & icc_op[1];
  assign type_all    = icc_type == dcache_icc_pkg::ICC_TYPE_ALL;
  assign type_setway = icc_type == dcache_icc_pkg::ICC_TYPE_SETWAY;
  // pure invalidate needs no array reads
  assign inv_only    = op_inv & ~op_cln & (type_all | type_setway);
  assign walk_go     = cur_idle & icc_req & lsu_no_op & vb_idle;

  //============================================================
  // walk FSM
  //============================================================
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state_q <= dcache_icc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_icc_pkg::IDLE: begin
        if (walk_go) begin
          state_d = inv_only ? dcache_icc_pkg::INV_ALL : dcache_icc_pkg::DIRTY_RD;
        end
      end
      dcache_icc_pkg::INV_ALL:   if (cnt_done) state_d = dcache_icc_pkg::CLR_VB;
      dcache_icc_pkg::DIRTY_RD:  state_d = dcache_icc_pkg::DIRTY_WEN;
      dcache_icc_pkg::DIRTY_WEN: state_d = dcache_icc_pkg::CHECK;
      dcache_icc_pkg::CHECK: begin
        state_d = (op_cln & |way_dirty) ? dcache_icc_pkg::TAG_RD : dcache_icc_pkg::TAG_WT;
      end
      dcache_icc_pkg::TAG_RD:    state_d = dcache_icc_pkg::TAG_WEN;
      // tag read data is on the bus in this cycle
      dcache_icc_pkg::TAG_WEN: begin
        state_d = (op_cln & dcache_tagvld) ? dcache_icc_pkg::WFVB : dcache_icc_pkg::CHECK;
      end
      dcache_icc_pkg::WFVB:      if (vb_grant) state_d = dcache_icc_pkg::DATA;
      dcache_icc_pkg::DATA:      if (data_last) state_d = dcache_icc_pkg::CHECK;
      dcache_icc_pkg::TAG_WT: begin
        state_d = cnt_done ? dcache_icc_pkg::CLR_VB : dcache_icc_pkg::DIRTY_RD;
      end
      dcache_icc_pkg::CLR_VB:    if (vb_empty) state_d = dcache_icc_pkg::IDLE;
      default:                   state_d = dcache_icc_pkg::IDLE;
    endcase
  end

  // lowest numbered remaining dirty way
  always_comb begin
    first_way = '0;
    for (int w = dcache_icc_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (way_dirty[w]) begin
        first_way = dcache_icc_pkg::WAY_W'(w);
      end
    end
  end

  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_way <= '0;
    end else if (state_q == dcache_icc_pkg::CHECK) begin
      cur_way <= first_way;
    end
  end

  //============================================================
  // strobes and handshake outputs
  //============================================================
  assign cur_idle      = state_q == dcache_icc_pkg::IDLE;
  assign cur_inv_all   = state_q == dcache_icc_pkg::INV_ALL;
  assign cur_dirty_rd  = state_q == dcache_icc_pkg::DIRTY_RD;
  assign cur_dirty_wen = state_q == dcache_icc_pkg::DIRTY_WEN;
  assign cur_tag_rd    = state_q == dcache_icc_pkg::TAG_RD;
  assign cur_tag_wen   = state_q == dcache_icc_pkg::TAG_WEN;
  assign cur_wfvb      = state_q == dcache_icc_pkg::WFVB;
  assign cur_data      = state_q == dcache_icc_pkg::DATA;
  assign cur_tag_wt    = state_q == dcache_icc_pkg::TAG_WT;

  assign cnt_start = cur_idle & icc_req;
  assign sync_req  = cur_idle & icc_req;
  assign idle      = cur_idle & ~icc_req;
  assign icc_done  = (state_q == dcache_icc_pkg::CLR_VB) & vb_empty;
  assign vb_req    = cur_wfvb;

  a_start_legal: assert property (@(posedge icc_fsm_clk) disable iff (!cpurst_b)
    walk_go |-> (icc_op != 2'b00) && (type_all || type_setway));

  // grant only answers a pending slot request
  a_grant_on_req: assert property (@(posedge icc_fsm_clk) disable iff (!cpurst_b)
    vb_grant |-> vb_req);

endmodule

//--- rtl/icc_set_walker.sv
//============================================================
// set counter for the maintenance walk
// end of walk detect and set index select
//============================================================
`timescale 1ns/1ns

module icc_set_walker #(
  parameter int SET_W = dcache_icc_pkg::DEFAULT_SET_W
) (
  input  logic              icc_fsm_clk,
  input  logic              cpurst_b,
  input  logic              cnt_start,
  input  logic              type_all,
  input  logic              type_setway,
  input  logic              cur_inv_all,
  input  logic              cur_tag_wt,
  input  logic [SET_W-1:0]  addr_set,
  output logic [SET_W-1:0]  set_idx,
  output logic              cnt_done
);

  logic [SET_W-1:0] cnt_q;

  // counts down from the last set for ALL, single pass otherwise
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cnt_q <= '0;
    end else if (cnt_start) begin
      cnt_q <= type_all ? '1 : '0;
    end else if (cur_inv_all | cur_tag_wt) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign cnt_done = cnt_q == '0;
  assign set_idx  = type_setway ? addr_set : cnt_q;

endmodule

//--- rtl/icc_line_state.sv
//============================================================
// per set dirty vector and tag capture
// way select from the request and the remaining dirty mask
//============================================================
`timescale 1ns/1ns

module icc_line_state (
  input  logic                                 icc_fsm_clk,
  input  logic                                 cpurst_b,
  input  logic                                 cur_dirty_wen,
  input  logic                                 cur_tag_wen,
  input  logic [dcache_icc_pkg::WAY_W-1:0]     cur_way,
  input  logic                                 type_setway,
  input  logic [dcache_icc_pkg::WAY_W-1:0]     addr_way,
  input  logic [dcache_icc_pkg::NUM_WAYS-1:0]  dcache_dirty,
  input  logic [dcache_icc_pkg::TAG_W-1:0]     dcache_tag,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]  way_sel,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]  way_dirty,
  output logic [dcache_icc_pkg::TAG_W-1:0]     line_tag
);

  logic [dcache_icc_pkg::NUM_WAYS-1:0] dirty_q;

  // a visited way drops out of the vector so CHECK moves on
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      dirty_q <= '0;
    end else if (cur_dirty_wen) begin
      dirty_q <= dcache_dirty;
    end else if (cur_tag_wen) begin
      dirty_q[cur_way] <= 1'b0;
    end
  end

  // tag of the line being written back
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      line_tag <= '0;
    end else if (cur_tag_wen) begin
      line_tag <= dcache_tag;
    end
  end

  assign way_sel   = type_setway ? dcache_icc_pkg::NUM_WAYS'(1) << addr_way : '1;
  assign way_dirty = dirty_q & way_sel;

endmodule

//--- rtl/icc_array_req.sv
//============================================================
// tag, dirty and data array requests
// decoded from the current FSM state
//============================================================
`timescale 1ns/1ns

module icc_array_req #(
  parameter int SET_W = dcache_icc_pkg::DEFAULT_SET_W
) (
  input  logic                                         icc_fsm_clk,
  input  logic                                         cur_inv_all,
  input  logic                                         cur_dirty_rd,
  input  logic                                         cur_tag_rd,
  input  logic                                         cur_tag_wt,
  input  logic                                         cur_data,
  input  logic                                         op_inv,
  input  logic                                         op_cln,
  input  logic                                         type_all,
  input  logic [dcache_icc_pkg::WAY_W-1:0]             cur_way,
  input  logic [dcache_icc_pkg::NUM_WAYS-1:0]          way_sel,
  input  logic [SET_W-1:0]                             set_idx,
  input  logic [dcache_icc_pkg::BEAT_W-1:0]            beat,
  output logic                                         tag_req,
  output logic                                         tag_wen,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]          tag_way,
  output logic [SET_W-1:0]                             tag_idx,
  output logic                                         dirty_req,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]          dirty_clr,
  output logic [SET_W-1:0]                             dirty_idx,
  output logic                                         data_req,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]          data_way,
  output logic [SET_W+dcache_icc_pkg::BEAT_W-1:0]      data_idx
);

  logic                                 tag_wr;
  logic                                 dirty_wr;
  logic [dcache_icc_pkg::NUM_WAYS-1:0]  cur_way_oh;

  assign cur_way_oh = dcache_icc_pkg::NUM_WAYS'(1) << cur_way;

  // tag array, write invalidates the selected ways
  assign tag_wr  = cur_inv_all | (cur_tag_wt & op_inv);
  assign tag_req = tag_wr | cur_tag_rd;
  assign tag_wen = tag_wr;
  assign tag_way = cur_tag_rd ? cur_way_oh : way_sel;
  assign tag_idx = set_idx;

  // dirty array
  assign dirty_wr  = (cur_inv_all & type_all) | (cur_tag_wt & op_cln);
  assign dirty_req = dirty_wr | cur_dirty_rd;
  assign dirty_clr = {dcache_icc_pkg::NUM_WAYS{dirty_wr}} & way_sel;
  assign dirty_idx = set_idx;

  // data array, one beat per DATA cycle
  assign data_req = cur_data;
  assign data_way = cur_way_oh;
  assign data_idx = {set_idx, beat};

  a_tag_rd_wr_excl: assert property (@(posedge icc_fsm_clk)
    !(cur_tag_rd && tag_wr));

endmodule

//--- rtl/icc_vb_feed.sv
//============================================================
// victim buffer feed
// beat counter, beat valid stage, line address and data
//============================================================
`timescale 1ns/1ns

module icc_vb_feed #(
  parameter int SET_W = dcache_icc_pkg::DEFAULT_SET_W
) (
  input  logic                                      icc_fsm_clk,
  input  logic                                      cpurst_b,
  input  logic                                      cur_wfvb,
  input  logic                                      cur_data,
  input  logic                                      vb_grant,
  input  logic [dcache_icc_pkg::TAG_W-1:0]          line_tag,
  input  logic [SET_W-1:0]                          set_idx,
  input  logic [dcache_icc_pkg::LINE_W-1:0]         dcache_data,
  output logic [dcache_icc_pkg::BEAT_W-1:0]         beat,
  output logic                                      data_last,
  output logic [dcache_icc_pkg::TAG_W+SET_W-1:0]    vb_addr,
  output logic [dcache_icc_pkg::LINE_W-1:0]         vb_data,
  output logic                                      vb_data_vld
);

  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      beat <= '0;
    end else if (cur_wfvb & vb_grant) begin
      beat <= '0;
    end else if (cur_data) begin
      beat <= beat + 1'b1;
    end
  end

  // array data arrives one cycle after the read
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      vb_data_vld <= 1'b0;
    end else begin
      vb_data_vld <= cur_data;
    end
  end

  assign data_last = beat == '1;
  assign vb_addr   = {line_tag, set_idx};
  assign vb_data   = dcache_data;

  a_beat_burst: assert property (@(posedge icc_fsm_clk) disable iff (!cpurst_b)
    vb_data_vld [*4] |=> !vb_data_vld);

endmodule

//--- rtl/dcache_icc.sv
//============================================================
// dcache maintenance controller top level
// connects the walk FSM, set walker, line state capture,
// array request decode and victim buffer feed
//============================================================
`timescale 1ns/1ns

module dcache_icc #(
  parameter int SET_W = dcache_icc_pkg::DEFAULT_SET_W
) (
  input  logic                                              icc_fsm_clk,
  input  logic                                              cpurst_b,
  input  logic                                              icc_req,
  input  logic [1:0]                                        icc_op,
  input  logic [1:0]                                        icc_type,
  input  logic [31:0]                                       icc_addr,
  input  logic                                              lsu_no_op,
  input  logic                                              vb_idle,
  input  logic                                              vb_grant,
  input  logic                                              vb_empty,
  input  logic [dcache_icc_pkg::NUM_WAYS-1:0]               dcache_dirty,
  input  logic [dcache_icc_pkg::TAG_W-1:0]                  dcache_tag,
  input  logic                                              dcache_tagvld,
  input  logic [dcache_icc_pkg::LINE_W-1:0]                 dcache_data,
  output logic                                              icc_done,
  output logic                                              sync_req,
  output logic                                              idle,
  output logic                                              tag_req,
  output logic                                              tag_wen,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]               tag_way,
  output logic [SET_W-1:0]                                  tag_idx,
  output logic                                              dirty_req,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]               dirty_clr,
  output logic [SET_W-1:0]                                  dirty_idx,
  output logic                                              data_req,
  output logic [dcache_icc_pkg::NUM_WAYS-1:0]               data_way,
  output logic [SET_W+dcache_icc_pkg::BEAT_W-1:0]           data_idx,
  output logic                                              vb_req,
  output logic [dcache_icc_pkg::TAG_W+SET_W-1:0]            vb_addr,
  output logic [dcache_icc_pkg::LINE_W-1:0]                 vb_data,
  output logic                                              vb_data_vld
);

  logic                                 op_inv;
  logic                                 op_cln;
  logic                                 type_all;
  logic                                 type_setway;
  logic                                 cur_inv_all;
  logic                                 cur_dirty_rd;
  logic                                 cur_dirty_wen;
  logic                                 cur_tag_rd;
  logic                                 cur_tag_wen;
  logic                                 cur_wfvb;
  logic                                 cur_data;
  logic                                 cur_tag_wt;
  logic                                 cnt_start;
  logic                                 cnt_done;
  logic                                 data_last;
  logic [dcache_icc_pkg::WAY_W-1:0]     cur_way;
  logic [dcache_icc_pkg::NUM_WAYS-1:0]  way_sel;
  logic [dcache_icc_pkg::NUM_WAYS-1:0]  way_dirty;
  logic [dcache_icc_pkg::TAG_W-1:0]     line_tag;
  logic [dcache_icc_pkg::BEAT_W-1:0]    beat;
  logic [SET_W-1:0]                     set_idx;

  icc_ctrl u_ctrl (
    .icc_fsm_clk(icc_fsm_clk), .cpurst_b(cpurst_b), .icc_req(icc_req),
    .icc_op(icc_op), .icc_type(icc_type), .lsu_no_op(lsu_no_op),
    .vb_idle(vb_idle), .vb_grant(vb_grant), .vb_empty(vb_empty),
    .dcache_tagvld(dcache_tagvld), .way_dirty(way_dirty), .cnt_done(cnt_done),
    .data_last(data_last), .op_inv(op_inv), .op_cln(op_cln),
    .type_all(type_all), .type_setway(type_setway), .cur_inv_all(cur_inv_all),
    .cur_dirty_rd(cur_dirty_rd), .cur_dirty_wen(cur_dirty_wen),
    .cur_tag_rd(cur_tag_rd), .cur_tag_wen(cur_tag_wen), .cur_wfvb(cur_wfvb),
    .cur_data(cur_data), .cur_tag_wt(cur_tag_wt), .cnt_start(cnt_start),
    .cur_way(cur_way), .icc_done(icc_done), .sync_req(sync_req),
    .idle(idle), .vb_req(vb_req)
  );

  // set field sits at address bit 6 upward
  icc_set_walker #(.SET_W(SET_W)) u_set_walker (
    .icc_fsm_clk(icc_fsm_clk), .cpurst_b(cpurst_b), .cnt_start(cnt_start),
    .type_all(type_all), .type_setway(type_setway), .cur_inv_all(cur_inv_all),
    .cur_tag_wt(cur_tag_wt), .addr_set(icc_addr[6 +: SET_W]),
    .set_idx(set_idx), .cnt_done(cnt_done)
  );

  icc_line_state u_line_state (
    .icc_fsm_clk(icc_fsm_clk), .cpurst_b(cpurst_b), .cur_dirty_wen(cur_dirty_wen),
    .cur_tag_wen(cur_tag_wen), .cur_way(cur_way), .type_setway(type_setway),
    .addr_way(icc_addr[31:30]), .dcache_dirty(dcache_dirty), .dcache_tag(dcache_tag),
    .way_sel(way_sel), .way_dirty(way_dirty), .line_tag(line_tag)
  );

  icc_array_req #(.SET_W(SET_W)) u_array_req (
    .icc_fsm_clk(icc_fsm_clk), .cur_inv_all(cur_inv_all), .cur_dirty_rd(cur_dirty_rd),
    .cur_tag_rd(cur_tag_rd), .cur_tag_wt(cur_tag_wt), .cur_data(cur_data),
    .op_inv(op_inv), .op_cln(op_cln), .type_all(type_all), .cur_way(cur_way),
    .way_sel(way_sel), .set_idx(set_idx), .beat(beat), .tag_req(tag_req),
    .tag_wen(tag_wen), .tag_way(tag_way), .tag_idx(tag_idx), .dirty_req(dirty_req),
    .dirty_clr(dirty_clr), .dirty_idx(dirty_idx), .data_req(data_req),
    .data_way(data_way), .data_idx(data_idx)
  );

  icc_vb_feed #(.SET_W(SET_W)) u_vb_feed (
    .icc_fsm_clk(icc_fsm_clk), .cpurst_b(cpurst_b), .cur_wfvb(cur_wfvb),
    .cur_data(cur_data), .vb_grant(vb_grant), .line_tag(line_tag),
    .set_idx(set_idx), .dcache_data(dcache_data), .beat(beat),
    .data_last(data_last), .vb_addr(vb_addr), .vb_data(vb_data),
    .vb_data_vld(vb_data_vld)
  );

endmodule

//--- sim/dcache_model.sv
//============================================================
// behavioral tag, dirty and data arrays of the 4-way dcache
// victim buffer grant and drain, write counters
//============================================================
`timescale 1ns/1ns

module dcache_model #(
  parameter int SET_W = 4
) (
  input  logic                icc_fsm_clk,
  input  logic                cpurst_b,
  input  logic [7:0]          grant_dly,
  input  logic [7:0]          empty_dly,
  input  logic                clr_cnt,
  input  logic                load_en,
  input  logic [SET_W-1:0]    load_set,
  input  logic [1:0]          load_way,
  input  logic [27:0]         load_tag,
  input  logic                load_vld,
  input  logic                load_dirty,
  input  logic                tag_req,
  input  logic                tag_wen,
  input  logic [3:0]          tag_way,
  input  logic [SET_W-1:0]    tag_idx,
  input  logic                dirty_req,
  input  logic [3:0]          dirty_clr,
  input  logic [SET_W-1:0]    dirty_idx,
  input  logic                data_req,
  input  logic [3:0]          data_way,
  input  logic [SET_W+1:0]    data_idx,
  input  logic                vb_req,
  input  logic                vb_data_vld,
  output logic [3:0]          dcache_dirty,
  output logic [27:0]         dcache_tag,
  output logic                dcache_tagvld,
  output logic [127:0]        dcache_data,
  output logic                vb_grant,
  output logic                vb_empty,
  output int                  tag_wr_cnt,
  output int                  dirty_clr_cnt
);

  localparam int NSETS = 1 << SET_W;

  logic [27:0] tag_mem   [NSETS][4];
  logic        vld_mem   [NSETS][4];
  logic        dirty_mem [NSETS][4];
  logic [7:0]  gcnt;
  logic [7:0]  ecnt;

  function automatic logic [1:0] oh_to_idx(input logic [3:0] oh);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 0; i < 4; i++) begin
      if (oh[i]) idx = 2'(i);
    end
    return idx;
  endfunction

  always @(posedge icc_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      dcache_dirty  <= 4'd0;
      dcache_tag    <= 28'd0;
      dcache_tagvld <= 1'b0;
      dcache_data   <= 128'd0;
      vb_grant      <= 1'b0;
      vb_empty      <= 1'b1;
      gcnt          <= 8'd0;
      ecnt          <= 8'd0;
      tag_wr_cnt    <= 0;
      dirty_clr_cnt <= 0;
    end else begin
      if (load_en) begin
        tag_mem[load_set][load_way]   = load_tag;
        vld_mem[load_set][load_way]   = load_vld;
        dirty_mem[load_set][load_way] = load_dirty;
      end
      // tag array, write means invalidate
      if (tag_req && tag_wen) begin
        for (int w = 0; w < 4; w++) begin
          if (tag_way[w]) vld_mem[tag_idx][w] = 1'b0;
        end
      end else if (tag_req) begin
        dcache_tag    <= tag_mem[tag_idx][oh_to_idx(tag_way)];
        dcache_tagvld <= vld_mem[tag_idx][oh_to_idx(tag_way)];
      end
      tag_wr_cnt <= clr_cnt ? 0 : tag_wr_cnt + int'(tag_req && tag_wen);
      if (dirty_req && |dirty_clr) begin
        for (int w = 0; w < 4; w++) begin
          if (dirty_clr[w]) dirty_mem[dirty_idx][w] = 1'b0;
        end
      end else if (dirty_req) begin
        dcache_dirty <= {dirty_mem[dirty_idx][3], dirty_mem[dirty_idx][2],
                         dirty_mem[dirty_idx][1], dirty_mem[dirty_idx][0]};
      end
      dirty_clr_cnt <= clr_cnt ? 0 : dirty_clr_cnt + int'(dirty_req && |dirty_clr);
      // beat pattern is set, way, beat and a fixed marker
      if (data_req) begin
        dcache_data <= {32'(data_idx[SET_W+1:2]), 32'(oh_to_idx(data_way)),
                        32'(data_idx[1:0]), 32'hA5C3_0F1E};
      end
      // slot grant after grant_dly cycles of request
      if (vb_req && !vb_grant) begin
        if (gcnt >= grant_dly) vb_grant <= 1'b1;
        else gcnt <= gcnt + 8'd1;
      end else begin
        vb_grant <= 1'b0;
        gcnt     <= 8'd0;
      end
      // drains empty_dly cycles after the last beat
      if (vb_data_vld) begin
        ecnt     <= empty_dly;
        vb_empty <= 1'b0;
      end else if (ecnt != 8'd0) begin
        ecnt <= ecnt - 8'd1;
      end else begin
        vb_empty <= 1'b1;
      end
    end
  end

endmodule

//--- sim/tb_dcache_icc.sv
//============================================================
// testbench for the dcache maintenance controller
// clock, reset, LFSR fill, stimulus table, checks, watchdog
//============================================================
`timescale 1ns/1ns

module tb_dcache_icc;

  localparam int SET_W = 4;
  localparam int NSETS = 1 << SET_W;
  localparam int NROWS = 7;
  localparam int WD_CYC = NROWS * NSETS * 40 + NROWS * 80 + 40;

  typedef struct {
    logic [1:0] op;
    logic [1:0] typ;
    int way;
    int set;
    int gdly;
    int edly;
    int fill;
    int exp_tagw;
    int exp_dclr;
  } row_t;

  // fill: 0 random, 1 target dirty and valid, 2 target clean
  row_t tbl [NROWS] = '{
    '{2'b01, dcache_icc_pkg::ICC_TYPE_ALL,    0, 0, 0, 1,  0, 16, 16},
    '{2'b01, dcache_icc_pkg::ICC_TYPE_SETWAY, 2, 5, 0, 1,  0, 1,  0},
    '{2'b10, dcache_icc_pkg::ICC_TYPE_SETWAY, 1, 3, 2, 2,  1, 0,  1},
    '{2'b10, dcache_icc_pkg::ICC_TYPE_SETWAY, 0, 7, 0, 1,  2, 0,  1},
    '{2'b10, dcache_icc_pkg::ICC_TYPE_ALL,    0, 0, 1, 3,  0, 0,  16},
    '{2'b11, dcache_icc_pkg::ICC_TYPE_ALL,    0, 0, 1, 2,  0, 16, 16},
    '{2'b11, dcache_icc_pkg::ICC_TYPE_SETWAY, 3, 9, 20, 15, 1, 1, 1}
  };

  logic icc_fsm_clk, cpurst_b, icc_req, lsu_no_op, vb_idle, vb_grant, vb_empty;
  logic [1:0] icc_op, icc_type;
  logic [31:0] icc_addr;
  logic [3:0] dcache_dirty, tag_way, dirty_clr, data_way;
  logic [27:0] dcache_tag, load_tag;
  logic dcache_tagvld, icc_done, sync_req, idle, tag_req, tag_wen, dirty_req, data_req;
  logic [127:0] dcache_data, vb_data;
  logic [SET_W-1:0] tag_idx, dirty_idx, load_set;
  logic [SET_W+1:0] data_idx;
  logic vb_req, vb_data_vld, clr_cnt, load_en, load_vld, load_dirty;
  logic [27+SET_W:0] vb_addr;
  logic [7:0] grant_dly, empty_dly;
  logic [1:0] load_way;
  int tag_wr_cnt, dirty_clr_cnt;

  logic [27:0] sh_tag [NSETS][4];
  logic sh_vld [NSETS][4];
  logic sh_dirty [NSETS][4];
  logic wb_seen [NSETS][4];
  logic [15:0] lfsr;
  row_t cur;
  int errors, checks, wb_cnt, beat_n, wb_set, wb_way;
  logic prev_req, prev_grant;

  dcache_icc #(.SET_W(SET_W)) u_dcache_icc (.*);

  dcache_model #(.SET_W(SET_W)) u_model (.*);

  initial begin
    icc_fsm_clk = 1'b0;
    forever #5 icc_fsm_clk = ~icc_fsm_clk;
  end

  initial begin
    #(WD_CYC * 10);
    $display("timeout: the maintenance walk did not finish in time");
    $display("Regression failed");
    $finish;
  end

  task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                           input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic selected(input int s, input int w);
    return cur.typ == dcache_icc_pkg::ICC_TYPE_ALL || (s == cur.set && w == cur.way);
  endfunction

  function automatic logic expect_wb(input int s, input int w);
    return selected(s, w) && cur.op[1] && sh_vld[s][w] && sh_dirty[s][w];
  endfunction

  // tag low bits carry way and set so a write-back names its line
  task automatic fill_arrays();
    logic [31:0] r;
    for (int s = 0; s < NSETS; s++) begin
      for (int w = 0; w < 4; w++) begin
        take_bits(22, r);
        sh_tag[s][w] = {r[21:2], 4'(w), 4'(s)};
        sh_vld[s][w] = r[1];
        sh_dirty[s][w] = r[0];
        if (cur.fill != 0 && s == cur.set && w == cur.way) begin
          sh_vld[s][w] = 1'b1;
          sh_dirty[s][w] = cur.fill == 1;
        end
        wb_seen[s][w] = 1'b0;
        @(posedge icc_fsm_clk);
        load_en <= 1'b1;
        load_set <= SET_W'(s);
        load_way <= 2'(w);
        load_tag <= sh_tag[s][w];
        load_vld <= sh_vld[s][w];
        load_dirty <= sh_dirty[s][w];
      end
    end
    @(posedge icc_fsm_clk);
    load_en <= 1'b0;
  endtask

  task automatic watch_cycle();
    logic [27:0] t;
    if (vb_data_vld) begin
      if (beat_n == 0) begin
        t = vb_addr[27+SET_W:SET_W];
        wb_set = int'(vb_addr[SET_W-1:0]);
        wb_way = int'(t[5:4]);
        check_val(128'(t), 128'(sh_tag[wb_set][wb_way]), "write-back tag");
        check_val(128'(expect_wb(wb_set, wb_way)), 128'd1, "write-back of a selected line");
        check_val(128'(wb_seen[wb_set][wb_way]), 128'd0, "line written back once");
      end
      check_val(vb_data, {32'(wb_set), 32'(wb_way), 32'(beat_n), 32'hA5C3_0F1E}, "beat data");
      beat_n++;
      if (beat_n == 4) begin
        beat_n = 0;
        wb_cnt++;
        wb_seen[wb_set][wb_way] = 1'b1;
      end
    end
    if (prev_req && !prev_grant && !vb_req) check_val(128'd0, 128'd1, "vb_req held to grant");
    if (icc_done) check_val(128'(vb_empty), 128'd1, "done waits for vb_empty");
    prev_req = vb_req;
    prev_grant = vb_grant;
  endtask

  task automatic run_row();
    int exp_wb;
    logic ev;
    logic ed;
    fill_arrays();
    exp_wb = 0;
    for (int s = 0; s < NSETS; s++) begin
      for (int w = 0; w < 4; w++) exp_wb += int'(expect_wb(s, w));
    end
    @(posedge icc_fsm_clk);
    clr_cnt <= 1'b1;
    grant_dly <= 8'(cur.gdly);
    empty_dly <= 8'(cur.edly);
    @(posedge icc_fsm_clk);
    clr_cnt <= 1'b0;
    icc_req <= 1'b1;
    icc_op <= cur.op;
    icc_type <= cur.typ;
    icc_addr <= {2'(cur.way), 20'd0, 4'(cur.set), 6'd0};
    // request held while the LSU and the victim buffer are busy
    lsu_no_op <= 1'b0;
    vb_idle <= 1'b0;
    for (int c = 0; c < 5; c++) begin
      @(posedge icc_fsm_clk);
      check_val(128'({sync_req, idle}), 128'b10, "sync_req while the walk waits");
      check_val(128'({tag_req, dirty_req, data_req, vb_req}), 128'd0,
                "no array access while waiting");
      if (c == 2) lsu_no_op <= 1'b1;
    end
    vb_idle <= 1'b1;
    wb_cnt = 0;
    beat_n = 0;
    do begin
      @(posedge icc_fsm_clk);
      watch_cycle();
    end while (!icc_done);
    icc_req <= 1'b0;
    @(posedge icc_fsm_clk);
    check_val(128'(idle), 128'd1, "idle after done");
    check_val(128'(icc_done), 128'd0, "single done pulse");
    check_val(128'(wb_cnt), 128'(exp_wb), "write-back count");
    check_val(128'(tag_wr_cnt), 128'(cur.exp_tagw), "tag write count");
    check_val(128'(dirty_clr_cnt), 128'(cur.exp_dclr), "dirty clear count");
    for (int s = 0; s < NSETS; s++) begin
      for (int w = 0; w < 4; w++) begin
        ev = sh_vld[s][w] & ~(selected(s, w) & cur.op[0]);
        ed = sh_dirty[s][w] & ~(selected(s, w) &
             (cur.op[1] | (cur.op[0] & cur.typ == dcache_icc_pkg::ICC_TYPE_ALL)));
        check_val(128'(u_model.vld_mem[s][w]), 128'(ev), $sformatf("valid s%0d w%0d", s, w));
        check_val(128'(u_model.dirty_mem[s][w]), 128'(ed), $sformatf("dirty s%0d w%0d", s, w));
      end
    end
  endtask

  initial begin
    cpurst_b = 1'b0;
    icc_req = 1'b0;
    icc_op = 2'b00;
    icc_type = 2'b00;
    icc_addr = 32'd0;
    lsu_no_op = 1'b1;
    vb_idle = 1'b1;
    clr_cnt = 1'b0;
    load_en = 1'b0;
    load_set = '0;
    load_way = 2'd0;
    load_tag = 28'd0;
    load_vld = 1'b0;
    load_dirty = 1'b0;
    grant_dly = 8'd0;
    empty_dly = 8'd1;
    lfsr = 16'd28130;
    errors = 0;
    checks = 0;
    prev_req = 1'b0;
    prev_grant = 1'b0;
    repeat (16) @(posedge icc_fsm_clk);
    cpurst_b <= 1'b1;
    @(posedge icc_fsm_clk);
    check_val(128'(idle), 128'd1, "idle after reset");
    check_val(128'(icc_done), 128'd0, "icc_done after reset");
    check_val(128'(vb_req), 128'd0, "vb_req after reset");
    check_val(128'(sync_req), 128'd0, "sync_req after reset");
    check_val(128'({tag_req, dirty_req, data_req}), 128'd0, "array requests after reset");
    for (int i = 0; i < NROWS; i++) begin
      cur = tbl[i];
      run_row();
    end
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- dcache_icc.f
rtl/dcache_icc_pkg.sv
rtl/icc_ctrl.sv
rtl/icc_set_walker.sv
rtl/icc_line_state.sv
rtl/icc_array_req.sv
rtl/icc_vb_feed.sv
rtl/dcache_icc.sv
sim/dcache_model.sv
sim/tb_dcache_icc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is decided by the printed result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f dcache_icc.f --top-module tb_dcache_icc \
  -o tb_dcache_icc \
  && ./obj_dir/tb_dcache_icc | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
